// ==== thumbDecoder_consts.svh ====
`ifndef THUMB_DECODER_CONSTS_SVH
`define THUMB_DECODER_CONSTS_SVH

// ****************************************
// Widths
// ****************************************

`define THUMB_W      16         // Thumb half-word
`define ARM_W        32         // ARM instruction word
`define BL_PREFIX_W  11         // Upper BL offset kept between the two halves

// ****************************************
// Fixed fields
// ****************************************

`define COND_AL      4'b1110    // Always
`define REG_SP       4'd13      // Stack pointer
`define REG_PC       4'd15      // Program counter

`endif

// ==== thumbIsaPkg.sv ====
`include "thumbDecoder_consts.svh"

package thumbIsaPkg;

    // Thumb side of the translation

    typedef logic [`THUMB_W-1:0]     thumbHalf_t;    // One Thumb instruction
    typedef logic [2:0]              loReg_t;        // Register r0..r7
    typedef logic [`BL_PREFIX_W-1:0] blPrefix_t;     // Offset bits 22..12 of BL

endpackage

// ==== armIsaPkg.sv ====
`include "thumbDecoder_consts.svh"

package armIsaPkg;

    // ARM side of the translation

    typedef logic [`ARM_W-1:0] armWord_t;    // One ARM instruction
    typedef logic [3:0]        armCond_t;    // Bits 31..28
    typedef logic [3:0]        armReg_t;     // Register r0..r15

    // Bits 24..21 of a data-processing word
    typedef enum logic [3:0] {
        DP_AND = 4'b0000,
        DP_EOR = 4'b0001,
        DP_SUB = 4'b0010,
        DP_RSB = 4'b0011,    // NEG uses RSB #0
        DP_ADD = 4'b0100,
        DP_ADC = 4'b0101,
        DP_SBC = 4'b0110,
        DP_RSC = 4'b0111,
        DP_TST = 4'b1000,
        DP_TEQ = 4'b1001,
        DP_CMP = 4'b1010,
        DP_CMN = 4'b1011,
        DP_ORR = 4'b1100,
        DP_MOV = 4'b1101,
        DP_BIC = 4'b1110,
        DP_MVN = 4'b1111
    } dpOpcode_t;

endpackage

// ==== thumbAluExpander.sv ====
`timescale 1ns/1ps
`include "thumbDecoder_consts.svh"

module thumbAluExpander
    import thumbIsaPkg::*, armIsaPkg::*;
(
    input  thumbHalf_t halfWord,
    output logic       aluHit,
    output armWord_t   aluWord
);

    loReg_t     rdnLo;      // Destination, also first source
    loReg_t     rmLo;
    loReg_t     op3Lo;      // Third register or imm3
    loReg_t     rImmLo;     // Register of the imm8 forms
    armReg_t    rdn;
    armReg_t    rm;
    armReg_t    op3;
    armReg_t    rImm;
    armReg_t    hiRd;       // H1 joined to Rd
    armReg_t    hiRm;       // H2 joined to Rm
    logic [3:0] aluOp;

    assign rdnLo  = halfWord[2:0];
    assign rmLo   = halfWord[5:3];
    assign op3Lo  = halfWord[8:6];
    assign rImmLo = halfWord[10:8];
    assign rdn    = {1'b0, rdnLo};
    assign rm     = {1'b0, rmLo};
    assign op3    = {1'b0, op3Lo};
    assign rImm   = {1'b0, rImmLo};
    assign hiRd   = {halfWord[7], halfWord[2:0]};
    assign hiRm   = {halfWord[6], halfWord[5:3]};
    assign aluOp  = halfWord[9:6];

    // Data-processing word, always executed
    function automatic armWord_t dpWord(
        input logic        imm,
        input dpOpcode_t   op,
        input logic        setFlags,
        input armReg_t     rn,
        input armReg_t     rd,
        input logic [11:0] op2
    );
        return {`COND_AL, 2'b00, imm, op, setFlags, rn, rd, op2};
    endfunction

    // ****************************************
    // Format decode
    // ****************************************

    always_comb begin
        aluHit  = 1'b1;
        aluWord = '0;
        casez (halfWord[15:6])
            10'b00011?????: begin   // ADD1, SUB1, ADD3, SUB3
                aluWord = dpWord(halfWord[10], halfWord[9] ? DP_SUB : DP_ADD, 1'b1,
                                 rm, rdn, {8'h00, op3});
            end
            10'b000???????: begin   // LSL, LSR, ASR by imm5
                aluWord = dpWord(1'b0, DP_MOV, 1'b1, 4'h0, rdn,
                                 {halfWord[10:6], halfWord[12:11], 1'b0, rm});
            end
            10'b001???????: begin   // imm8 forms
                case (halfWord[12:11])
                    2'b00:   aluWord = dpWord(1'b1, DP_MOV, 1'b1, 4'h0, rImm,
                                              {4'h0, halfWord[7:0]});
                    2'b01:   aluWord = dpWord(1'b1, DP_CMP, 1'b1, rImm, 4'h0,
                                              {4'h0, halfWord[7:0]});
                    2'b10:   aluWord = dpWord(1'b1, DP_ADD, 1'b1, rImm, rImm,
                                              {4'h0, halfWord[7:0]});
                    default: aluWord = dpWord(1'b1, DP_SUB, 1'b1, rImm, rImm,
                                              {4'h0, halfWord[7:0]});
                endcase
            end
            10'b010000????: begin   // Register ALU ops
                case (aluOp)
                    4'b0010: aluWord = dpWord(1'b0, DP_MOV, 1'b1, 4'h0, rdn,
                                              {rm, 4'b0001, rdn});       // LSL by Rs
                    4'b0011: aluWord = dpWord(1'b0, DP_MOV, 1'b1, 4'h0, rdn,
                                              {rm, 4'b0011, rdn});       // LSR by Rs
                    4'b0100: aluWord = dpWord(1'b0, DP_MOV, 1'b1, 4'h0, rdn,
                                              {rm, 4'b0101, rdn});       // ASR by Rs
                    4'b0111: aluWord = dpWord(1'b0, DP_MOV, 1'b1, 4'h0, rdn,
                                              {rm, 4'b0111, rdn});       // ROR by Rs
                    4'b1001: aluWord = dpWord(1'b1, DP_RSB, 1'b1, rm, rdn, 12'h000);
                    4'b1101: aluWord = {`COND_AL, 8'h01, rdn, 4'h0, rdn, 4'b1001, rm};
                    default: begin
                        // Remaining Thumb op numbers equal the ARM opcodes
                        aluWord = dpWord(1'b0, dpOpcode_t'(aluOp), 1'b1,
                                         (aluOp == 4'b1111) ? 4'h0 : rdn,
                                         (aluOp[3:2] == 2'b10) ? 4'h0 : rdn,
                                         {8'h00, rm});
                    end
                endcase
            end
            10'b01000100??: aluWord = dpWord(1'b0, DP_ADD, 1'b0, hiRd, hiRd, {8'h00, hiRm});
            10'b01000101??: aluWord = dpWord(1'b0, DP_CMP, 1'b1, hiRd, 4'h0, {8'h00, hiRm});
            10'b01000110??: aluWord = dpWord(1'b0, DP_MOV, 1'b0, 4'h0, hiRd, {8'h00, hiRm});
            10'b10110000??: begin   // ADD7, SUB4 on SP by imm7 words
                aluWord = dpWord(1'b1, halfWord[7] ? DP_SUB : DP_ADD, 1'b0,
                                 `REG_SP, `REG_SP, {4'hF, 1'b0, halfWord[6:0]});
            end
            default: aluHit = 1'b0;
        endcase
    end

endmodule

// ==== thumbMemExpander.sv ====
`timescale 1ns/1ps
`include "thumbDecoder_consts.svh"

module thumbMemExpander
    import thumbIsaPkg::*, armIsaPkg::*;
(
    input  thumbHalf_t halfWord,
    output logic       memHit,
    output armWord_t   memWord,
    output logic       pcRelative
);

    loReg_t     rdLo;
    loReg_t     rbLo;       // Base register
    loReg_t     roLo;       // Offset register
    loReg_t     rImmLo;     // Rd of the imm8 forms
    armReg_t    rd;
    armReg_t    rb;
    armReg_t    ro;
    armReg_t    rImm;
    logic [4:0] imm5;
    logic [7:0] imm8;

    assign rdLo   = halfWord[2:0];
    assign rbLo   = halfWord[5:3];
    assign roLo   = halfWord[8:6];
    assign rImmLo = halfWord[10:8];
    assign rd     = {1'b0, rdLo};
    assign rb     = {1'b0, rbLo};
    assign ro     = {1'b0, roLo};
    assign rImm   = {1'b0, rImmLo};
    assign imm5   = halfWord[10:6];
    assign imm8   = halfWord[7:0];

    // Pre-indexed, offset added, no write-back
    function automatic armWord_t sdtWord(
        input logic        regOff,
        input logic        byteAcc,
        input logic        load,
        input armReg_t     rn,
        input armReg_t     rdt,
        input logic [11:0] offset
    );
        return {`COND_AL, 2'b01, regOff, 2'b11, byteAcc, 1'b0, load, rn, rdt, offset};
    endfunction

    always_comb begin
        memHit     = 1'b1;
        memWord    = '0;
        pcRelative = 1'b0;
        case (halfWord[15:11])
            5'b01100, 5'b01101, 5'b01110, 5'b01111: begin   // imm5 offset
                memWord = sdtWord(1'b0, halfWord[12], halfWord[11], rb, rd,
                                  halfWord[12] ? {7'h00, imm5} : {5'h00, imm5, 2'b00});
            end
            5'b01010, 5'b01011: begin
                if (!halfWord[9])   // Word and byte only
                    memWord = sdtWord(1'b1, halfWord[10], halfWord[11], rb, rd, {8'h00, ro});
                else
                    memHit = 1'b0;
            end
            5'b01001: begin         // LDR from PC
                memWord    = sdtWord(1'b0, 1'b0, 1'b1, `REG_PC, rImm, {2'b00, imm8, 2'b00});
                pcRelative = 1'b1;
            end
            5'b10010, 5'b10011: begin
                memWord = sdtWord(1'b0, 1'b0, halfWord[11], `REG_SP, rImm,
                                  {2'b00, imm8, 2'b00});
            end
            5'b10100, 5'b10101: begin   // ADD5 from PC, ADD6 from SP
                memWord    = {`COND_AL, 3'b001, DP_ADD, 1'b0,
                              halfWord[11] ? `REG_SP : `REG_PC, rImm, 4'hF, imm8};
                pcRelative = ~halfWord[11];
            end
            default: memHit = 1'b0;
        endcase
    end

endmodule

// ==== thumbBranchExpander.sv ====
`timescale 1ns/1ps
`include "thumbDecoder_consts.svh"

module thumbBranchExpander
    import thumbIsaPkg::*, armIsaPkg::*;
(
    input  logic       CLK,
    input  logic       nRESET,
    input  logic       CLKEN,
    input  thumbHalf_t halfWord,
    output logic       brHit,
    output armWord_t   brWord,
    output logic       blSecond
);

    blPrefix_t                     blPrefix;    // Upper offset from first BL half
    logic                          blFirst;
    logic                          blLoad;
    logic [2*`BL_PREFIX_W-1:0]     blOffset;
    armCond_t                      bCond;

    assign bCond    = halfWord[11:8];
    assign blLoad   = CLKEN & blFirst;
    assign blOffset = {blPrefix, halfWord[10:0]};

    // ****************************************
    // BL prefix register
    // ****************************************

    always_ff @(posedge CLK) begin
        if (!nRESET)
            blPrefix <= '0;
        else if (blLoad)
            blPrefix <= halfWord[10:0];
    end

    // ****************************************
    // Branch decode
    // ****************************************

    always_comb begin
        brHit    = 1'b1;
        brWord   = '0;
        blFirst  = 1'b0;
        blSecond = 1'b0;
        casez (halfWord[15:7])
            9'b1101?????: begin
                if (bCond == 4'b1111)    // SWI
                    brWord = {`COND_AL, 4'b1111, 16'h0000, halfWord[7:0]};
                else
                    brWord = {bCond, 4'b1010, {16{halfWord[7]}}, halfWord[7:0]};
            end
            9'b11100????: begin         // Unconditional B
                brWord = {`COND_AL, 4'b1010, {13{halfWord[10]}}, halfWord[10:0]};
            end
            9'b11110????: begin         // BL first half, no operation
                blFirst = 1'b1;
                brWord  = {`COND_AL, 28'h0000000};
            end
            9'b11111????: begin         // BL second half
                blSecond = 1'b1;
                brWord   = {`COND_AL, 4'b1011, {2{blOffset[21]}}, blOffset};
            end
            9'b010001110: brWord = {`COND_AL, 24'h12FFF1, halfWord[6:3]};   // BX
            default:      brHit  = 1'b0;
        endcase
    end

    // The second half must read the prefix the first half left behind
    assert property (@(posedge CLK) disable iff (!nRESET) !(blSecond && blLoad))
        else $error("BL prefix loaded while the second BL half is decoded");

endmodule

// ==== thumbDecodeSelect.sv ====
`timescale 1ns/1ps
`include "thumbDecoder_consts.svh"

module thumbDecodeSelect
    import armIsaPkg::*;
(
    input  armWord_t            InstForDecode,
    input  logic                HalfWordAddress,
    input  logic                ThumbDecoderEn,
    output logic [`THUMB_W-1:0] halfWord,
    input  logic                aluHit,
    input  armWord_t            aluWord,
    input  logic                memHit,
    input  armWord_t            memWord,
    input  logic                brHit,
    input  armWord_t            brWord,
    input  logic                pcRelative,
    input  logic                blSecond,
    output armWord_t            ExpandedInst,
    output logic                ThADR,
    output logic                ThBL
);

    armWord_t thumbWord;    // Merged expander result

    assign halfWord = HalfWordAddress ? InstForDecode[31:16] : InstForDecode[15:0];

    // AND-OR merge, zero when nothing matched
    assign thumbWord = ({`ARM_W{aluHit}} & aluWord)
                     | ({`ARM_W{memHit}} & memWord)
                     | ({`ARM_W{brHit}}  & brWord);

    assign ExpandedInst = ThumbDecoderEn ? thumbWord : InstForDecode;   // ARM bypass
    assign ThADR        = ThumbDecoderEn & pcRelative;
    assign ThBL         = ThumbDecoderEn & blSecond;

    // Expander encodings must not overlap
    always_comb begin
        assert final ($onehot0({aluHit, memHit, brHit}))
            else $error("More than one expander claims half-word %h", halfWord);
    end

endmodule

// ==== ThumbDecoder.sv ====
`timescale 1ns/1ps

module ThumbDecoder
    import thumbIsaPkg::*, armIsaPkg::*;
(
    input  logic     CLK,
    input  logic     nRESET,
    input  logic     CLKEN,
    input  armWord_t InstForDecode,      // Fetch word
    input  logic     HalfWordAddress,    // 1 selects bits 31..16
    input  logic     ThumbDecoderEn,     // Thumb state
    output armWord_t ExpandedInst,
    output logic     ThADR,              // ADD5 or PC-relative LDR
    output logic     ThBL                // Second half of BL
);

    thumbHalf_t halfWord;
    logic       aluHit;
    armWord_t   aluWord;
    logic       memHit;
    armWord_t   memWord;
    logic       pcRelative;
    logic       brHit;
    armWord_t   brWord;
    logic       blSecond;

    thumbDecodeSelect u_thumbDecodeSelect (
        .InstForDecode   (InstForDecode),
        .HalfWordAddress (HalfWordAddress),
        .ThumbDecoderEn  (ThumbDecoderEn),
        .halfWord        (halfWord),
        .aluHit          (aluHit),
        .aluWord         (aluWord),
        .memHit          (memHit),
        .memWord         (memWord),
        .brHit           (brHit),
        .brWord          (brWord),
        .pcRelative      (pcRelative),
        .blSecond        (blSecond),
        .ExpandedInst    (ExpandedInst),
        .ThADR           (ThADR),
        .ThBL            (ThBL)
    );

    thumbAluExpander u_thumbAluExpander (
        .halfWord (halfWord),
        .aluHit   (aluHit),
        .aluWord  (aluWord)
    );

    thumbMemExpander u_thumbMemExpander (
        .halfWord   (halfWord),
        .memHit     (memHit),
        .memWord    (memWord),
        .pcRelative (pcRelative)
    );

    thumbBranchExpander u_thumbBranchExpander (
        .CLK      (CLK),
        .nRESET   (nRESET),
        .CLKEN    (CLKEN),
        .halfWord (halfWord),
        .brHit    (brHit),
        .brWord   (brWord),
        .blSecond (blSecond)
    );

endmodule

// ==== tbThumbDecoder.sv ====
`timescale 1ns/1ps

module tbThumbDecoder;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_BYPASS   = 64;
    localparam int NUM_HALVES   = 32;
    localparam int NUM_FORMATS  = 21;
    localparam int NUM_ROUNDS   = 8;
    localparam int NUM_BL       = 16;
    localparam int TEST_CYCLES  = 2 * RESET_CYCLES + NUM_BYPASS + 2 * NUM_HALVES
                                + NUM_FORMATS * NUM_ROUNDS + 16 + 4 * NUM_BL + 8;
    localparam int MARGIN       = 1000;             // ns

    logic        CLK;
    logic        nRESET;
    logic        CLKEN;
    logic [31:0] InstForDecode;
    logic        HalfWordAddress;
    logic        ThumbDecoderEn;
    logic [31:0] ExpandedInst;
    logic        ThADR;
    logic        ThBL;

    logic [31:0] lcgState;
    logic [10:0] modelPrefix;                       // Reference copy of the BL prefix
    logic [15:0] selHalf;
    logic [31:0] expWord;
    logic        expAdr;
    logic        expBl;
    int          errorCount;

    ThumbDecoder u_ThumbDecoder (
        .CLK             (CLK),
        .nRESET          (nRESET),
        .CLKEN           (CLKEN),
        .InstForDecode   (InstForDecode),
        .HalfWordAddress (HalfWordAddress),
        .ThumbDecoderEn  (ThumbDecoderEn),
        .ExpandedInst    (ExpandedInst),
        .ThADR           (ThADR),
        .ThBL            (ThBL)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // ****************************************
    // Reference expansion
    // ****************************************

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] armDataProc(input logic i, input logic [3:0] op,
                                                input logic s, input logic [3:0] rn,
                                                input logic [3:0] rd, input logic [11:0] op2);
        return {4'hE, 2'b00, i, op, s, rn, rd, op2};
    endfunction

    function automatic logic [31:0] armLoadStore(input logic regOff, input logic b,
                                                 input logic l, input logic [3:0] rn,
                                                 input logic [3:0] rd, input logic [11:0] off);
        return {4'hE, 2'b01, regOff, 1'b1, 1'b1, b, 1'b0, l, rn, rd, off};   // P=1 U=1 W=0
    endfunction

    // Thumb ALU op number to the ARM word
    function automatic logic [31:0] aluRegRef(input logic [3:0] op, input logic [3:0] rd,
                                              input logic [3:0] rs);
        case (op)
            4'h0: return armDataProc(1'b0, 4'h0, 1'b1, rd, rd, {8'h00, rs});
            4'h1: return armDataProc(1'b0, 4'h1, 1'b1, rd, rd, {8'h00, rs});
            4'h2: return armDataProc(1'b0, 4'hD, 1'b1, 4'h0, rd, {rs, 4'b0001, rd});
            4'h3: return armDataProc(1'b0, 4'hD, 1'b1, 4'h0, rd, {rs, 4'b0011, rd});
            4'h4: return armDataProc(1'b0, 4'hD, 1'b1, 4'h0, rd, {rs, 4'b0101, rd});
            4'h5: return armDataProc(1'b0, 4'h5, 1'b1, rd, rd, {8'h00, rs});
            4'h6: return armDataProc(1'b0, 4'h6, 1'b1, rd, rd, {8'h00, rs});
            4'h7: return armDataProc(1'b0, 4'hD, 1'b1, 4'h0, rd, {rs, 4'b0111, rd});
            4'h8: return armDataProc(1'b0, 4'h8, 1'b1, rd, 4'h0, {8'h00, rs});
            4'h9: return armDataProc(1'b1, 4'h3, 1'b1, rs, rd, 12'h000);     // RSBS #0
            4'hA: return armDataProc(1'b0, 4'hA, 1'b1, rd, 4'h0, {8'h00, rs});
            4'hB: return armDataProc(1'b0, 4'hB, 1'b1, rd, 4'h0, {8'h00, rs});
            4'hC: return armDataProc(1'b0, 4'hC, 1'b1, rd, rd, {8'h00, rs});
            4'hD: return {4'hE, 7'b0000000, 1'b1, rd, 4'h0, rd, 4'b1001, rs};  // MULS
            4'hE: return armDataProc(1'b0, 4'hE, 1'b1, rd, rd, {8'h00, rs});
            default: return armDataProc(1'b0, 4'hF, 1'b1, 4'h0, rd, {8'h00, rs});
        endcase
    endfunction

    function automatic logic [31:0] refExpand(input logic [15:0] h, input logic [10:0] prefix);
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  ri;
        logic [3:0]  hd;
        logic [3:0]  hs;
        logic [21:0] blOff;
        rd    = {1'b0, h[2:0]};
        rs    = {1'b0, h[5:3]};
        ri    = {1'b0, h[10:8]};
        hd    = {h[7], h[2:0]};
        hs    = {h[6], h[5:3]};
        blOff = {prefix, h[10:0]};
        casez (h)
            16'b00011???????????: return armDataProc(h[10], h[9] ? 4'h2 : 4'h4, 1'b1, rs, rd,
                                                     {9'h000, h[8:6]});
            16'b000?????????????: return armDataProc(1'b0, 4'hD, 1'b1, 4'h0, rd,
                                                     {h[10:6], h[12:11], 1'b0, rs});
            16'b00100???????????: return armDataProc(1'b1, 4'hD, 1'b1, 4'h0, ri, {4'h0, h[7:0]});
            16'b00101???????????: return armDataProc(1'b1, 4'hA, 1'b1, ri, 4'h0, {4'h0, h[7:0]});
            16'b00110???????????: return armDataProc(1'b1, 4'h4, 1'b1, ri, ri, {4'h0, h[7:0]});
            16'b00111???????????: return armDataProc(1'b1, 4'h2, 1'b1, ri, ri, {4'h0, h[7:0]});
            16'b010000??????????: return aluRegRef(h[9:6], rd, rs);
            16'b01000100????????: return armDataProc(1'b0, 4'h4, 1'b0, hd, hd, {8'h00, hs});
            16'b01000101????????: return armDataProc(1'b0, 4'hA, 1'b1, hd, 4'h0, {8'h00, hs});
            16'b01000110????????: return armDataProc(1'b0, 4'hD, 1'b0, 4'h0, hd, {8'h00, hs});
            16'b010001110???????: return {4'hE, 24'h12FFF1, hs};
            16'b01001???????????: return armLoadStore(1'b0, 1'b0, 1'b1, 4'd15, ri,
                                                      {2'b00, h[7:0], 2'b00});
            16'b0101??0?????????: return armLoadStore(1'b1, h[10], h[11], rs, rd,
                                                      {9'h000, h[8:6]});
            16'b011?????????????: return armLoadStore(1'b0, h[12], h[11], rs, rd,
                                                      h[12] ? {7'h00, h[10:6]}
                                                            : {5'h00, h[10:6], 2'b00});
            16'b1001????????????: return armLoadStore(1'b0, 1'b0, h[11], 4'd13, ri,
                                                      {2'b00, h[7:0], 2'b00});
            16'b1010????????????: return armDataProc(1'b1, 4'h4, 1'b0, h[11] ? 4'd13 : 4'd15,
                                                     ri, {4'hF, h[7:0]});   // imm8 ROR 30
            16'b10110000????????: return armDataProc(1'b1, h[7] ? 4'h2 : 4'h4, 1'b0, 4'd13,
                                                     4'd13, {5'b11110, h[6:0]});
            16'b1101????????????: begin
                if (h[11:8] == 4'hF)
                    return {4'hE, 4'hF, 16'h0000, h[7:0]};                 // SWI
                return {h[11:8], 4'hA, {16{h[7]}}, h[7:0]};
            end
            16'b11100???????????: return {4'hE, 4'hA, {13{h[10]}}, h[10:0]};
            16'b11110???????????: return {4'hE, 28'h0000000};
            16'b11111???????????: return {4'hE, 4'hB, {2{blOff[21]}}, blOff};
            default:              return 32'h0000_0000;                    // Dropped or undefined
        endcase
    endfunction

    // One encoding per format, register fields from r
    function automatic logic [15:0] sampleFormat(input int fmt, input logic [31:0] r);
        case (fmt)
            0:  return {5'b00011, r[10:0]};
            1:  return {5'b00000, r[10:0]};
            2:  return {5'b00001, r[10:0]};
            3:  return {5'b00010, r[10:0]};
            4:  return {3'b001, r[12:0]};
            5:  return {6'b010000, r[9:0]};
            6:  return {8'b01000100, r[7:0]};
            7:  return {8'b01000101, r[7:0]};
            8:  return {8'b01000110, r[7:0]};
            9:  return {9'b010001110, r[6:0]};
            10: return {5'b01001, r[10:0]};
            11: return {4'b0101, r[11:10], 1'b0, r[8:0]};
            12: return {3'b011, r[12:0]};
            13: return {4'b1001, r[11:0]};
            14: return {4'b1010, r[11:0]};
            15: return {8'b10110000, r[7:0]};
            16: return {4'b1101, r[11:0]};
            17: return {5'b11100, r[10:0]};
            18: return {4'b1100, r[11:0]};                                    // LDMIA
            19: return {7'b1011010, r[8:0]};                                   // PUSH
            default: return {5'b10001, r[10:0]};                              // LDRH
        endcase
    endfunction

    function automatic logic [31:0] placeHalf(input logic [15:0] h, input logic hw,
                                              input logic [15:0] other);
        return hw ? {h, other} : {other, h};
    endfunction

    assign selHalf = HalfWordAddress ? InstForDecode[31:16] : InstForDecode[15:0];

    always_comb begin
        expWord = ThumbDecoderEn ? refExpand(selHalf, modelPrefix) : InstForDecode;
        expAdr  = ThumbDecoderEn & ((selHalf[15:11] == 5'b01001) || (selHalf[15:11] == 5'b10100));
        expBl   = ThumbDecoderEn & (selHalf[15:11] == 5'b11111);
    end

    always @(posedge CLK) begin
        if (!nRESET)
            modelPrefix <= '0;
        else if (CLKEN && selHalf[15:11] == 5'b11110)
            modelPrefix <= selHalf[10:0];
    end

    // ****************************************
    // Checks
    // ****************************************

    task automatic abortRun(input string why);
        errorCount++;
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        abortRun($sformatf("ERROR at %0t ns: %s expected %h, actual %h",
                           $time, name, expVal, actVal));
    endtask

    assert property (@(negedge CLK) disable iff (!nRESET) ExpandedInst == expWord)
        else reportMismatch("ExpandedInst", expWord, ExpandedInst);
    assert property (@(negedge CLK) disable iff (!nRESET) ThADR == expAdr)
        else reportMismatch("ThADR", {31'h0, expAdr}, {31'h0, ThADR});
    assert property (@(negedge CLK) disable iff (!nRESET) ThBL == expBl)
        else reportMismatch("ThBL", {31'h0, expBl}, {31'h0, ThBL});

    always @(negedge CLK) begin
        if (nRESET && !ThumbDecoderEn)
            assert (!ThADR && !ThBL)
                else abortRun("A Thumb flag is high while the decoder is in ARM mode");
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + MARGIN);
        abortRun("Watchdog expired before the tests completed");
    end

    // ****************************************
    // Stimulus
    // ****************************************

    task automatic driveCycle(input logic [31:0] word, input logic hw, input logic en,
                              input logic clkEn);
        @(posedge CLK);
        #2;
        InstForDecode   = word;
        HalfWordAddress = hw;
        ThumbDecoderEn  = en;
        CLKEN           = clkEn;
    endtask

    task automatic resetDut();
        @(posedge CLK);
        #2;
        nRESET = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        nRESET = 1'b1;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        int          fmt;
        errorCount      = 0;
        lcgState        = 32'h6db364d3;
        nRESET          = 1'b0;
        CLKEN           = 1'b1;
        InstForDecode   = '0;
        HalfWordAddress = 1'b0;
        ThumbDecoderEn  = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        nRESET = 1'b1;

        r = lcgNext();                                       // Lone second BL half, prefix 0
        driveCycle(placeHalf({5'b11111, r[10:0]}, r[31], r[26:11]), r[31], 1'b1, 1'b1);

        for (int i = 0; i < NUM_BYPASS; i++) begin           // ARM bypass
            r = lcgNext();
            r2 = lcgNext();
            driveCycle(r, r2[31], 1'b0, r2[30]);
        end

        for (int i = 0; i < NUM_HALVES; i++) begin           // Half-word select
            fmt = i % NUM_FORMATS;
            r = lcgNext();
            r2 = lcgNext();
            r = {sampleFormat((fmt + 7) % NUM_FORMATS, r2), sampleFormat(fmt, r)};
            driveCycle(r, 1'b0, 1'b1, 1'b1);
            driveCycle(r, 1'b1, 1'b1, 1'b1);
        end

        for (int k = 0; k < NUM_ROUNDS; k++) begin           // Every format, random fields
            for (fmt = 0; fmt < NUM_FORMATS; fmt++) begin
                r = lcgNext();
                driveCycle(placeHalf(sampleFormat(fmt, r), r[31], r[31:16]), r[31], 1'b1, 1'b1);
            end
        end

        for (int op = 0; op < 16; op++) begin                // Each register ALU op
            r = lcgNext();
            driveCycle(placeHalf({6'b010000, op[3:0], r[5:0]}, r[31], r[31:16]),
                       r[31], 1'b1, 1'b1);
        end

        for (int i = 0; i < NUM_BL; i++) begin               // BL pairs
            r = lcgNext();
            driveCycle(placeHalf({5'b11110, r[10:0]}, r[31], r[26:11]), r[31], 1'b1, 1'b1);
            r = lcgNext();
            driveCycle(placeHalf({5'b11111, r[10:0]}, r[31], r[26:11]), r[31], 1'b1, 1'b1);
            r = lcgNext();
            driveCycle(placeHalf({5'b11110, r[10:0]}, r[31], r[26:11]), r[31], 1'b1, 1'b0);
            r = lcgNext();
            driveCycle(placeHalf({5'b11111, r[10:0]}, r[31], r[26:11]), r[31], 1'b1, 1'b1);
        end

        resetDut();                                          // Prefix back to zero
        r = lcgNext();
        driveCycle(placeHalf({5'b11111, r[10:0]}, r[31], r[26:11]), r[31], 1'b1, 1'b1);

        @(negedge CLK);
        @(negedge CLK);
        if (errorCount == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abortRun("One or more checks failed");
        end
    end

endmodule

// ==== vlog.f ====
+incdir+.
thumbIsaPkg.sv
armIsaPkg.sv
thumbAluExpander.sv
thumbMemExpander.sv
thumbBranchExpander.sv
thumbDecodeSelect.sv
ThumbDecoder.sv
tbThumbDecoder.sv
